// File: run_sim.sh
#!/usr/bin/env bash
# build and run the tag directory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    -f verilog.f \
    --top-module tag_dir_tb \
    --Mdir obj_dir \
    -o tag_dir_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/tag_dir_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit $sim_status
fi

exit 0

// File: test/tag_dir_tb.sv
`timescale 1ns/100ps
`include "tag_dir_consts.svh"

module tag_dir_tb
    import tag_dir_pkg::*;
();

    localparam int RESET_CYCLES  = 4;
    localparam int RANDOM_REQS   = 200;
    // one cycle per request, per test
    localparam int TEST_CYCLES   = RESET_CYCLES + 9 + 8 + 4 + 8 + RANDOM_REQS;
    localparam int TIMEOUT_LIMIT = 2 * TEST_CYCLES + 50;

    logic        clk;
    logic        rst_n;
    acc_req_t    acc;
    acc_rsp_t    rsp;
    int          cycle_cnt = 0;

    // reference model of the directory
    logic [2:0]          m_status [`LIST_DEPTH];
    logic [`INDEX_W-1:0] m_index  [`LIST_DEPTH];
    logic [`TAG_W-1:0]   free_order [$];
    logic [`TAG_W-1:0]   lru_order  [$];

    tag_dir_top dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .acc   (acc),
        .rsp   (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_LIMIT) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_LIMIT);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic model_reset();
        free_order.delete();
        lru_order.delete();
        for (int i = 0; i < `LIST_DEPTH; i++) begin
            m_status[i] = `ST_INVALID;
            m_index[i]  = '0;
            free_order.push_back(`TAG_W'(i));
        end
    endtask

    // highest matching tag wins, as for the directory
    function automatic logic model_lookup(input logic [`INDEX_W-1:0] idx,
                                          output logic [`TAG_W-1:0] tag);
        logic found;
        found = 1'b0;
        tag   = '0;
        for (int i = 0; i < `LIST_DEPTH; i++) begin
            if (m_status[i] != `ST_INVALID && m_index[i] == idx) begin
                found = 1'b1;
                tag   = `TAG_W'(i);
            end
        end
        return found;
    endfunction

    task automatic move_to_head(input logic [`TAG_W-1:0] tag);
        for (int i = 0; i < lru_order.size(); i++) begin
            if (lru_order[i] == tag) begin
                lru_order.delete(i);
                break;
            end
        end
        lru_order.push_front(tag);
    endtask

    // one request, checked against the model, model updated at the edge
    task automatic send(input logic [1:0] cmd, input logic [`INDEX_W-1:0] payload,
                        output acc_rsp_t got);
        acc_rsp_t          exp;
        logic              found;
        logic [`TAG_W-1:0] tag;
        @(negedge clk);
        acc.req           = 1'b1;
        acc.cmd           = cmd;
        acc.payload.index = payload;
        exp   = '0;
        found = model_lookup(payload, tag);
        if (cmd == `CMD_READ || cmd == `CMD_WRITE) begin
            if (found) begin
                exp.hit    = 1'b1;
                exp.status = m_status[tag];
                exp.index  = m_index[tag];
            end
        end else if (cmd == `CMD_ALLOC) begin
            if (free_order.size() != 0) begin
                tag = free_order[$];
            end else begin
                tag = lru_order[$];
            end
            exp.status = m_status[tag];
            exp.index  = m_index[tag];
            exp.tag    = tag;
        end
        #8;
        got = rsp;
        check("rsp.hit", 32'(rsp.hit), 32'(exp.hit));
        check("rsp.status", 32'(rsp.status), 32'(exp.status));
        check("rsp.index", 32'(rsp.index), 32'(exp.index));
        check("rsp.tag", 32'(rsp.tag), 32'(exp.tag));
        @(posedge clk);
        if ((cmd == `CMD_READ || cmd == `CMD_WRITE) && found) begin
            move_to_head(tag);
            if (cmd == `CMD_WRITE) begin
                m_status[tag] = `ST_DIRTY;
            end
        end else if (cmd == `CMD_ALLOC) begin
            if (free_order.size() != 0) begin
                void'(free_order.pop_back());
            end else begin
                void'(lru_order.pop_back());
            end
            lru_order.push_front(tag);
            m_status[tag] = `ST_FETCH;
            m_index[tag]  = payload;
        end else if (cmd == `CMD_FILL) begin
            m_status[payload[`TAG_W-1:0]] = `ST_VALID;
        end
    endtask

    task automatic lookups_miss_after_reset();
        acc_rsp_t got;
        logic [`INDEX_W-1:0] idx [4] = '{4'h0, 4'h5, 4'h9, 4'hf};
        for (int i = 0; i < 4; i++) begin
            send(`CMD_READ, idx[i], got);
            check("rsp", 32'(got), 32'h0);
            send(`CMD_WRITE, idx[i], got);
            check("rsp", 32'(got), 32'h0);
        end
        // idle cycle with an allocate code but no strobe
        @(negedge clk);
        acc.req = 1'b0;
        acc.cmd = `CMD_ALLOC;
        #8;
        check("rsp", 32'(rsp), 32'h0);
    endtask

    task automatic alloc_order_and_fetch();
        acc_rsp_t got;
        logic [`INDEX_W-1:0] idx [4] = '{4'h3, 4'h7, 4'ha, 4'hc};
        for (int i = 0; i < 4; i++) begin
            send(`CMD_ALLOC, idx[i], got);
            check("rsp.tag", 32'(got.tag), 32'(3 - i));
            check("rsp.status", 32'(got.status), 32'(`ST_INVALID));
        end
        for (int i = 0; i < 4; i++) begin
            send(`CMD_READ, idx[i], got);
            check("rsp.hit", 32'(got.hit), 32'h1);
            check("rsp.status", 32'(got.status), 32'(`ST_FETCH));
            check("rsp.index", 32'(got.index), 32'(idx[i]));
        end
    endtask

    // index 7 sits in line 2
    task automatic fill_then_write();
        acc_rsp_t got;
        send(`CMD_FILL, `INDEX_W'(2), got);
        send(`CMD_READ, 4'h7, got);
        check("rsp.status", 32'(got.status), 32'(`ST_VALID));
        send(`CMD_WRITE, 4'h7, got);
        check("rsp.status", 32'(got.status), 32'(`ST_VALID));
        send(`CMD_READ, 4'h7, got);
        check("rsp.status", 32'(got.status), 32'(`ST_DIRTY));
    endtask

    task automatic victim_selection();
        acc_rsp_t got;
        send(`CMD_READ, 4'h3, got);
        send(`CMD_READ, 4'ha, got);
        send(`CMD_READ, 4'hc, got);
        // line 2 with index 7 is now least recent and dirty
        send(`CMD_ALLOC, 4'h5, got);
        check("rsp.tag", 32'(got.tag), 32'h2);
        check("rsp.status", 32'(got.status), 32'(`ST_DIRTY));
        check("rsp.index", 32'(got.index), 32'h7);
        send(`CMD_READ, 4'h7, got);
        check("rsp.hit", 32'(got.hit), 32'h0);
        // touch line 3, the current tail, then allocate again
        send(`CMD_READ, 4'h3, got);
        send(`CMD_ALLOC, 4'h9, got);
        if (got.tag == `TAG_W'(3)) begin
            $display("the line touched just before was chosen as the victim");
            $display("test failed");
            $fatal(1, "wrong victim");
        end
        check("rsp.tag", 32'(got.tag), 32'h1);
        send(`CMD_READ, 4'ha, got);
        check("rsp.hit", 32'(got.hit), 32'h0);
    endtask

    task automatic random_traffic();
        acc_rsp_t            got;
        logic [1:0]          cmd;
        logic [`INDEX_W-1:0] idx;
        logic [`TAG_W-1:0]   tag;
        logic [`TAG_W-1:0]   fetching [$];
        for (int n = 0; n < RANDOM_REQS; n++) begin
            cmd = 2'($urandom);
            idx = `INDEX_W'($urandom);
            if (cmd == `CMD_ALLOC) begin
                // only absent indices get allocated
                while (model_lookup(idx, tag)) begin
                    idx = idx + `INDEX_W'(1);
                end
            end else if (cmd == `CMD_FILL) begin
                fetching.delete();
                for (int i = 0; i < `LIST_DEPTH; i++) begin
                    if (m_status[i] == `ST_FETCH) begin
                        fetching.push_back(`TAG_W'(i));
                    end
                end
                if (fetching.size() == 0) begin
                    cmd = `CMD_READ;
                end else begin
                    idx = `INDEX_W'(fetching[$urandom % fetching.size()]);
                end
            end
            send(cmd, idx, got);
        end
    endtask

    initial begin
        void'($urandom(97));
        rst_n    = 1'b0;
        acc      = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        lookups_miss_after_reset();
        alloc_order_and_fetch();
        fill_then_write();
        victim_selection();
        random_traffic();
        @(negedge clk);
        acc = '0;
        $display("test passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verilog
verilog/tag_dir_pkg.sv
verilog/line_lookup.sv
verilog/lru_chain.sv
verilog/line_state_table.sv
verilog/tag_dir_top.sv
test/tag_dir_tb.sv

// File: verilog/line_lookup.sv
`timescale 1ns/100ps
`include "tag_dir_consts.svh"

module line_lookup
    import tag_dir_pkg::*;
(
    input  acc_req_t                  acc,
    input  logic [`LIST_DEPTH-1:0]    entry_valid,
    input  logic [`INDEX_W-1:0]       entry_index [`LIST_DEPTH],
    output lookup_t                   lk
);

    logic              is_access;
    logic              match;
    logic [`TAG_W-1:0] match_tag;

    assign is_access = acc.req && (acc.cmd == `CMD_READ || acc.cmd == `CMD_WRITE);

    // ascending scan, so the highest matching tag wins
    always_comb begin
        match     = 1'b0;
        match_tag = '0;
        for (int i = 0; i < `LIST_DEPTH; i++) begin
            if (entry_valid[i] && entry_index[i] == acc.payload.index) begin
                match     = 1'b1;
                match_tag = `TAG_W'(i);
            end
        end
    end

    always_comb begin
        lk            = '0;
        lk.access_hit = is_access && match;
        lk.write_hit  = is_access && match && acc.cmd == `CMD_WRITE;
        lk.alloc      = acc.req && acc.cmd == `CMD_ALLOC;
        lk.fill       = acc.req && acc.cmd == `CMD_FILL;
        lk.hit_tag    = match_tag;
        // payload read as an index for lookups and allocate
        lk.index      = acc.payload.index;
        // and as a line tag for fill done
        lk.fill_tag   = acc.payload.fill.tag;
    end

endmodule

// File: verilog/line_state_table.sv
`timescale 1ns/100ps
`include "tag_dir_consts.svh"

module line_state_table
    import tag_dir_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  lookup_t                lk,
    input  logic [`TAG_W-1:0]      alloc_tag,
    output logic [`LIST_DEPTH-1:0] entry_valid,
    output logic [`INDEX_W-1:0]    entry_index [`LIST_DEPTH],
    output acc_rsp_t               rsp
);

    logic [2:0]          status_q [`LIST_DEPTH];
    logic [`INDEX_W-1:0] index_q  [`LIST_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LIST_DEPTH; i++) begin
                status_q[i] <= `ST_INVALID;
                index_q[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < `LIST_DEPTH; i++) begin
                if (lk.alloc && alloc_tag == `TAG_W'(i)) begin
                    status_q[i] <= `ST_FETCH;
                    index_q[i]  <= lk.index;
                end else if (lk.fill && lk.fill_tag == `TAG_W'(i)) begin
                    status_q[i] <= `ST_VALID;
                end else if (lk.write_hit && lk.hit_tag == `TAG_W'(i)) begin
                    status_q[i] <= `ST_DIRTY;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `LIST_DEPTH; i++) begin
            entry_valid[i] = status_q[i] != `ST_INVALID;
            entry_index[i] = index_q[i];
        end
    end

    // alloc reports the old contents so the caller can write back a victim
    always_comb begin
        rsp = '0;
        if (lk.access_hit) begin
            rsp.hit    = 1'b1;
            rsp.status = status_q[lk.hit_tag];
            rsp.index  = index_q[lk.hit_tag];
        end else if (lk.alloc) begin
            rsp.status = status_q[alloc_tag];
            rsp.index  = index_q[alloc_tag];
            rsp.tag    = alloc_tag;
        end
    end

endmodule

// File: verilog/lru_chain.sv
`timescale 1ns/100ps
`include "tag_dir_consts.svh"

module lru_chain
    import tag_dir_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  lookup_t           lk,
    output logic [`TAG_W-1:0] alloc_tag
);

    typedef struct packed {
        logic [`TAG_W-1:0] head;
        logic [`TAG_W-1:0] tail;
        logic [`LEN_W-1:0] len;
    } chain_t;

    chain_t            free_q;
    chain_t            lru_q;
    logic [`TAG_W-1:0] prev_q [`LIST_DEPTH];
    logic [`TAG_W-1:0] next_q [`LIST_DEPTH];

    logic              free_empty;
    logic              free_last;
    logic              lru_empty;
    logic              take_free;
    logic              move;
    logic [`TAG_W-1:0] move_tag;
    logic [`TAG_W-1:0] move_prev;
    logic [`TAG_W-1:0] move_next;
    logic              move_is_head;
    logic              move_is_tail;

    assign free_empty = free_q.len == '0;
    assign free_last  = free_q.tail == free_q.head;
    assign lru_empty  = lru_q.len == '0;

    // victim is the LRU tail once every line is in use
    assign alloc_tag = free_empty ? lru_q.tail : free_q.tail;

    assign take_free = lk.alloc && !free_empty;

    // a hit and a victim reuse both move a line already in the LRU chain
    assign move     = lk.access_hit || (lk.alloc && free_empty);
    assign move_tag = lk.access_hit ? lk.hit_tag : lru_q.tail;

    assign move_prev    = prev_q[move_tag];
    assign move_next    = next_q[move_tag];
    assign move_is_head = move_tag == lru_q.head;
    assign move_is_tail = move_tag == lru_q.tail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_q.head <= '0;
            free_q.tail <= `TAG_W'(`LIST_DEPTH - 1);
            free_q.len  <= `LEN_W'(`LIST_DEPTH);
            lru_q       <= '0;
            // free chain in tag order, links wrap around
            for (int i = 0; i < `LIST_DEPTH; i++) begin
                next_q[i] <= `TAG_W'((i + 1) % `LIST_DEPTH);
                prev_q[i] <= `TAG_W'((i + `LIST_DEPTH - 1) % `LIST_DEPTH);
            end
        end else if (take_free) begin
            free_q.tail <= prev_q[free_q.tail];
            free_q.len  <= free_last ? '0 : free_q.len - 1'b1;
            if (lru_empty) begin
                lru_q.tail <= free_q.tail;
            end else begin
                prev_q[lru_q.head]  <= free_q.tail;
                next_q[free_q.tail] <= lru_q.head;
            end
            lru_q.head <= free_q.tail;
            lru_q.len  <= lru_q.len + 1'b1;
        end else if (move && !move_is_head) begin
            // unlink
            next_q[move_prev] <= move_next;
            if (move_is_tail) begin
                lru_q.tail <= move_prev;
            end else begin
                prev_q[move_next] <= move_prev;
            end
            // relink at the head
            next_q[move_tag]   <= lru_q.head;
            prev_q[lru_q.head] <= move_tag;
            lru_q.head         <= move_tag;
        end
    end

endmodule

// File: verilog/tag_dir_consts.svh
`ifndef TAG_DIR_CONSTS_SVH
`define TAG_DIR_CONSTS_SVH

// directory geometry
`define LIST_DEPTH 4
`define TAG_W      2
`define INDEX_W    4
`define LEN_W      (`TAG_W + 1)

// access commands
`define CMD_WRITE 2'b00
`define CMD_READ  2'b01
`define CMD_ALLOC 2'b10
`define CMD_FILL  2'b11

// line status
`define ST_INVALID 3'b000
`define ST_FETCH   3'b100
`define ST_VALID   3'b001
`define ST_DIRTY   3'b010

`endif

// File: verilog/tag_dir_pkg.sv
`include "tag_dir_consts.svh"

package tag_dir_pkg;

    // fill done names a line directly, tag sits in the low bits
    typedef struct packed {
        logic [`INDEX_W-`TAG_W-1:0] pad;
        logic [`TAG_W-1:0]          tag;
    } fill_payload_t;

    typedef union packed {
        logic [`INDEX_W-1:0] index;
        fill_payload_t       fill;
    } req_payload_u;

    typedef struct packed {
        logic         req;
        logic [1:0]   cmd;
        req_payload_u payload;
    } acc_req_t;

    // decoded request, shared by the chain and the line table
    typedef struct packed {
        logic                access_hit;
        logic                write_hit;
        logic                alloc;
        logic                fill;
        logic [`TAG_W-1:0]   hit_tag;
        logic [`INDEX_W-1:0] index;
        logic [`TAG_W-1:0]   fill_tag;
    } lookup_t;

    typedef struct packed {
        logic                hit;
        logic [2:0]          status;
        logic [`INDEX_W-1:0] index;
        logic [`TAG_W-1:0]   tag;
    } acc_rsp_t;

endpackage

// File: verilog/tag_dir_top.sv
`timescale 1ns/100ps
`include "tag_dir_consts.svh"

module tag_dir_top
    import tag_dir_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  acc_req_t acc,
    output acc_rsp_t rsp
);

    lookup_t                lk;
    logic [`TAG_W-1:0]      alloc_tag;
    logic [`LIST_DEPTH-1:0] entry_valid;
    logic [`INDEX_W-1:0]    entry_index [`LIST_DEPTH];

    // decode and match
    line_lookup lookup_i (
        .acc         (acc),
        .entry_valid (entry_valid),
        .entry_index (entry_index),
        .lk          (lk)
    );

    lru_chain chain_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .lk        (lk),
        .alloc_tag (alloc_tag)
    );

    // per line status, index and response
    line_state_table table_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .lk          (lk),
        .alloc_tag   (alloc_tag),
        .entry_valid (entry_valid),
        .entry_index (entry_index),
        .rsp         (rsp)
    );

endmodule
